//--- int_exec_unit.f
+incdir+include
source/rv_pkg.sv
source/int_decoder.sv
source/reg_file.sv
source/operand_sel.sv
source/int_alu.sv
source/int_exec_unit.sv
tests/tb_int_exec_unit.sv

//--- Makefile
TOP := tb_int_exec_unit
BIN := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f int_exec_unit.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

//--- include/exec_vectors.svh
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// directed rows, included inside the testbench module.
// wb.rd is expected to equal instr[11:7] on data rows.
typedef struct packed {
  logic [31:0] instr;
  logic        exp_illegal;  // illegal pulse and no write-back.
  logic [31:0] exp_data;     // checked when exp_illegal is low.
} exec_vec_t;

localparam int NUM_VECTORS = 26;

localparam exec_vec_t VECTORS [NUM_VECTORS] = '{
  '{32'h00500093, 1'b0, 32'h00000005},  // addi x1, x0, 5.
  '{32'hFFD00113, 1'b0, 32'hFFFFFFFD},  // addi x2, x0, -3.
  '{32'h002081B3, 1'b0, 32'h00000002},  // add x3, x1, x2 with x2 forwarded.
  '{32'h40208233, 1'b0, 32'h00000008},  // sub x4, x1, x2.
  '{32'h001092B3, 1'b0, 32'h000000A0},  // sll x5, x1, x1.
  '{32'h00112333, 1'b0, 32'h00000001},  // slt x6, x2, x1.
  '{32'h001133B3, 1'b0, 32'h00000000},  // sltu x7, x2, x1.
  '{32'h0020C433, 1'b0, 32'hFFFFFFF8},  // xor x8, x1, x2.
  '{32'h001154B3, 1'b0, 32'h07FFFFFF},  // srl x9, x2, x1.
  '{32'h40115533, 1'b0, 32'hFFFFFFFF},  // sra x10, x2, x1.
  '{32'h0020E5B3, 1'b0, 32'hFFFFFFFD},  // or x11, x1, x2.
  '{32'h0020F633, 1'b0, 32'h00000005},  // and x12, x1, x2.
  '{32'h00012693, 1'b0, 32'h00000001},  // slti x13, x2, 0.
  '{32'hFFF0B713, 1'b0, 32'h00000001},  // sltiu x14, x1, -1.
  '{32'hFFF0C793, 1'b0, 32'hFFFFFFFA},  // xori x15, x1, -1.
  '{32'h0F00E813, 1'b0, 32'h000000F5},  // ori x16, x1, 0xf0.
  '{32'h7FF17893, 1'b0, 32'h000007FD},  // andi x17, x2, 0x7ff.
  '{32'h00409913, 1'b0, 32'h00000050},  // slli x18, x1, 4.
  '{32'h00415993, 1'b0, 32'h0FFFFFFF},  // srli x19, x2, 4.
  '{32'h40115A13, 1'b0, 32'hFFFFFFFE},  // srai x20, x2, 1.
  '{32'h00708013, 1'b0, 32'h0000000C},  // addi x0, x1, 7, write dropped.
  '{32'h00000AB3, 1'b0, 32'h00000000},  // add x21, x0, x0 reads zero.
  '{32'h00002083, 1'b1, 32'h00000000},  // load opcode is illegal.
  '{32'h06300092, 1'b1, 32'h00000000},  // low bits not 11.
  '{32'h00008B13, 1'b0, 32'h00000005},  // addi x22, x1, 0, x1 kept.
  '{32'h016B0BB3, 1'b0, 32'h0000000A}   // add x23, x22, x22 forwarded.
};

`endif

//--- tests/tb_int_exec_unit.sv
module tb_int_exec_unit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int XLEN        = 32;
  localparam int RESET_LIMIT = 40;   // cycles allowed until reset release.
  localparam int DRAIN_LIMIT = 8;    // cycles allowed for the outputs to go idle.
  localparam int NUM_RANDOM  = 200;

  `include "exec_vectors.svh"

  // what the DUT shows in the cycle after an instruction is sampled.
  typedef struct packed {
    rv_pkg::wb_tag_t tag;
    logic [XLEN-1:0] data;
    logic            illegal;
  } expect_t;

  logic            clk         = 1'b0;
  logic            arst_n      = 1'b0;
  logic            instr_valid = 1'b0;
  logic [31:0]     instr       = '0;
  rv_pkg::wb_tag_t wb;
  logic [XLEN-1:0] wb_data;
  logic            illegal;

  logic [XLEN-1:0] shadow [32];  // architectural state of the model.
  expect_t         pending;      // expectation for the word sampled last edge.
  integer          seed;

  int_exec_unit #(.XLEN(XLEN)) DUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb          (wb),
    .wb_data     (wb_data),
    .illegal     (illegal)
  );

  always #5 clk = ~clk;

  initial begin
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_tag(input rv_pkg::wb_tag_t got, input rv_pkg::wb_tag_t exp);
    if (exp.en) begin
      if (got !== exp) begin
        report_failure($sformatf("mismatch at %0t: wb got en=%b rd=%0d expected en=%b rd=%0d",
                                 $time, got.en, got.rd, exp.en, exp.rd));
      end
    end else if (got.en !== 1'b0) begin
      report_failure($sformatf("mismatch at %0t: wb.en got %b expected 0", $time, got.en));
    end
  endtask

  task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: wb_data got %h expected %h",
                               $time, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: illegal got %b expected %b",
                               $time, got, exp));
    end
  endtask

  task automatic check_outputs(input expect_t exp);
    check_tag(wb, exp.tag);
    if (exp.tag.en) begin
      check_data(wb_data, exp.data);  // data only means something with en.
    end
    check_flag(illegal, exp.illegal);
  endtask

  // outputs are stable at the falling edge, new word goes in right after.
  task automatic step(input logic valid, input logic [31:0] word, input expect_t next);
    @(negedge clk);
    check_outputs(pending);
    instr_valid = valid;
    instr       = word;
    pending     = next;
  endtask

  // rv32i result from the shadow registers, program order.
  function automatic logic [31:0] model_result(input logic [31:0] word);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic        is_op;
    logic [31:0] res;
    a     = shadow[word[19:15]];
    is_op = (word[6:0] == 7'b0110011);
    b     = is_op ? shadow[word[24:20]] : {{20{word[31]}}, word[31:20]};
    sh    = b[4:0];
    case (word[14:12])
      3'b000: res = (is_op && word[30]) ? a - b : a + b;  // sub only for r-type.
      3'b001: res = a << sh;
      3'b010: res = {31'b0, $signed(a) < $signed(b)};
      3'b011: res = {31'b0, a < b};
      3'b100: res = a ^ b;
      3'b101: begin
        if (word[30]) begin
          res = $signed(a) >>> sh;
        end else begin
          res = a >> sh;
        end
      end
      3'b110: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic expect_t model_issue(input logic [31:0] word);
    expect_t e;
    e        = '0;
    e.tag.en = 1'b1;
    e.tag.rd = word[11:7];
    e.data   = model_result(word);
    if (word[11:7] != 5'd0) begin
      shadow[word[11:7]] = e.data;  // x0 stays zero.
    end
    return e;
  endfunction

  // legal op or op-imm word, registers x0 to x15 so dependencies come up often.
  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [6:0]  funct7;
    logic [31:0] word;
    r   = $random(seed);
    f3  = r[3:1];
    rd  = {1'b0, r[8:5]};
    rs1 = {1'b0, r[12:9]};
    rs2 = {1'b0, r[16:13]};
    imm = r[28:17];
    if (r[0]) begin
      funct7 = (r[4] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
      word   = {funct7, rs2, rs1, f3, rd, 7'b0110011};
    end else begin
      if (f3 == 3'b001) begin
        imm = {7'b0000000, imm[4:0]};
      end else if (f3 == 3'b101) begin
        imm = {1'b0, r[4], 5'b00000, imm[4:0]};  // srli or srai.
      end
      word = {imm, rs1, f3, rd, 7'b0010011};
    end
    return word;
  endfunction

  initial begin
    expect_t     e;
    int          cycles;
    logic [31:0] word;
    seed    = 77179;
    pending = '0;
    for (int r = 0; r < 32; r++) begin
      shadow[r] = '0;
    end

    cycles = 0;
    while (arst_n !== 1'b1) begin
      if (cycles == RESET_LIMIT) begin
        report_failure("reset was not released in time");
      end
      @(negedge clk);
      cycles++;
    end

    for (int i = 0; i < NUM_VECTORS; i++) begin
      if (VECTORS[i].exp_illegal) begin
        e         = '0;
        e.illegal = 1'b1;  // no write-back, shadow untouched.
      end else begin
        e = model_issue(VECTORS[i].instr);
        if (e.data !== VECTORS[i].exp_data) begin
          report_failure($sformatf("table row %0d disagrees with the ISA model", i));
        end
      end
      step(1'b1, VECTORS[i].instr, e);
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      word = random_instr();
      step(1'b1, word, model_issue(word));
    end

    cycles = 0;
    step(1'b0, 32'h0, '0);
    while ((wb.en !== 1'b0) || (illegal !== 1'b0)) begin
      if (cycles == DRAIN_LIMIT) begin
        report_failure("outputs did not go idle at the end of the run");
      end
      step(1'b0, 32'h0, '0);
      cycles++;
    end
    step(1'b0, 32'h0, '0);

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- source/int_exec_unit.sv
module int_exec_unit #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            instr_valid,
  input  logic [31:0]     instr,
  output rv_pkg::wb_tag_t wb,
  output logic [XLEN-1:0] wb_data,
  output logic            illegal
);

  rv_pkg::dec_t    dec;
  logic            issue;
  logic [XLEN-1:0] rd1_data;
  logic [XLEN-1:0] rd2_data;
  logic [XLEN-1:0] opd1;
  logic [XLEN-1:0] opd2;

  int_decoder u_dec (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec         (dec),
    .issue       (issue),
    .illegal     (illegal)
  );

  reg_file #(.XLEN(XLEN)) u_rf (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rd1_data (rd1_data),
    .rd2_data (rd2_data),
    .wb       (wb),       // write port.
    .wb_data  (wb_data)
  );

  operand_sel #(.XLEN(XLEN)) u_opd (
    .dec      (dec),
    .rd1_data (rd1_data),
    .rd2_data (rd2_data),
    .wb       (wb),       // forwarding source.
    .wb_data  (wb_data),
    .opd1     (opd1),
    .opd2     (opd2)
  );

  int_alu #(.XLEN(XLEN)) u_alu (
    .clk     (clk),
    .arst_n  (arst_n),
    .issue   (issue),
    .ctl     (dec.ctl),
    .rd      (dec.rd),
    .opd1    (opd1),
    .opd2    (opd2),
    .wb      (wb),
    .wb_data (wb_data)
  );

endmodule

//--- source/int_alu.sv
module int_alu #(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              issue,
  input  rv_pkg::alu_ctl_t  ctl,
  input  rv_pkg::reg_addr_t rd,
  input  logic [XLEN-1:0]   opd1,
  input  logic [XLEN-1:0]   opd2,
  output rv_pkg::wb_tag_t   wb,
  output logic [XLEN-1:0]   wb_data
);

  localparam int SHW = $clog2(XLEN);  // shift amount width.

  typedef enum logic [2:0] {
    SEL_LOGI,
    SEL_ADD,
    SEL_SUB,
    SEL_SLL,
    SEL_SLT,
    SEL_SLTU,
    SEL_SRL,
    SEL_SRA
  } rslt_sel_e;

  logic [SHW-1:0]  shamt;
  logic [XLEN-1:0] rslt_logi;
  logic [XLEN-1:0] rslt_add;
  logic [XLEN-1:0] rslt_sub;
  logic [XLEN-1:0] rslt_sll;
  logic [XLEN-1:0] rslt_slt;
  logic [XLEN-1:0] rslt_sltu;
  logic [XLEN-1:0] rslt_srl;
  logic [XLEN-1:0] rslt_sra;
  rslt_sel_e       rslt_sel;
  rv_pkg::wb_tag_t tag_q;

  assign shamt = opd2[SHW-1:0];

  // every candidate is computed and registered.
  always_ff @(posedge clk) begin
    case (ctl.funct3)
      rv_pkg::XOR: rslt_logi <= opd1 ^ opd2;
      rv_pkg::OR:  rslt_logi <= opd1 | opd2;
      default:     rslt_logi <= opd1 & opd2;
    endcase
    rslt_add  <= opd1 + opd2;
    rslt_sub  <= opd1 - opd2;
    rslt_slt  <= XLEN'($signed(opd1) < $signed(opd2));
    rslt_sltu <= XLEN'(opd1 < opd2);
    rslt_sll  <= opd1 << shamt;
    rslt_srl  <= opd1 >> shamt;
    rslt_sra  <= $signed(opd1) >>> shamt;
  end

  // select registered alongside, used by the output mux a cycle later.
  always_ff @(posedge clk) begin
    case (ctl.funct3)
      rv_pkg::ADD_SUB: rslt_sel <= (ctl.r_type && ctl.alt) ? SEL_SUB : SEL_ADD;
      rv_pkg::SLL:     rslt_sel <= SEL_SLL;
      rv_pkg::SLT:     rslt_sel <= SEL_SLT;
      rv_pkg::SLTU:    rslt_sel <= SEL_SLTU;
      rv_pkg::SRL_SRA: rslt_sel <= ctl.alt ? SEL_SRA : SEL_SRL;  // srai by bit 30.
      default:         rslt_sel <= SEL_LOGI;
    endcase
  end

  always_comb begin
    case (rslt_sel)
      SEL_ADD:  wb_data = rslt_add;
      SEL_SUB:  wb_data = rslt_sub;
      SEL_SLL:  wb_data = rslt_sll;
      SEL_SLT:  wb_data = rslt_slt;
      SEL_SLTU: wb_data = rslt_sltu;
      SEL_SRL:  wb_data = rslt_srl;
      SEL_SRA:  wb_data = rslt_sra;
      default:  wb_data = rslt_logi;
    endcase
  end

  // tag follows its result through the same stage.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tag_q <= '0;
    end else begin
      tag_q.en <= issue;
      tag_q.rd <= rd;
    end
  end

  assign wb = tag_q;

  a_wb_after_issue: assert property (
    @(posedge clk) disable iff (!arst_n)
    issue |=> wb.en
  );

endmodule

//--- source/operand_sel.sv
module operand_sel #(
  parameter int XLEN = 32
) (
  input  rv_pkg::dec_t    dec,
  input  logic [XLEN-1:0] rd1_data,
  input  logic [XLEN-1:0] rd2_data,
  input  rv_pkg::wb_tag_t wb,
  input  logic [XLEN-1:0] wb_data,
  output logic [XLEN-1:0] opd1,
  output logic [XLEN-1:0] opd2
);

  logic            wb_live;
  logic            fwd1;
  logic            fwd2;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] imm_ext;

  // the result in flight is written only at the next edge, so
  // a dependent instruction right behind it must take it from here.
  assign wb_live = wb.en && (wb.rd != '0);
  assign fwd1    = wb_live && (wb.rd == dec.rs1);
  assign fwd2    = wb_live && (wb.rd == dec.rs2);

  assign opd1 = fwd1 ? wb_data : rd1_data;
  assign src2 = fwd2 ? wb_data : rd2_data;

  assign imm_ext = XLEN'($signed(dec.imm));  // widen for xlen above 32.

  assign opd2 = dec.use_imm ? imm_ext : src2;

endmodule

//--- source/reg_file.sv
module reg_file #(
  parameter int XLEN = 32
) (
  input  logic              clk,
  input  logic              arst_n,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output logic [XLEN-1:0]   rd1_data,
  output logic [XLEN-1:0]   rd2_data,
  input  rv_pkg::wb_tag_t   wb,
  input  logic [XLEN-1:0]   wb_data
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.rd != '0)) begin
      regs[wb.rd] <= wb_data;  // x0 writes dropped.
    end
  end

  // combinational reads, x0 hardwired.
  assign rd1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2_data = (rs2 == '0) ? '0 : regs[rs2];

  a_wb_written: assert property (
    @(posedge clk) disable iff (!arst_n)
    (wb.en && (wb.rd != '0)) |=> (regs[$past(wb.rd)] == $past(wb_data))
  );

endmodule

//--- source/int_decoder.sv
module int_decoder (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  output rv_pkg::dec_t dec,
  output logic        issue,
  output logic        illegal
);

  rv_pkg::opcode_e opc;
  logic            legal;
  logic            illegal_q;

  assign opc = rv_pkg::opcode_e'(instr[6:2]);

  // 32-bit encoding and one of the two integer groups.
  assign legal = (instr[1:0] == 2'b11) &&
                 ((opc == rv_pkg::OP_IMM) || (opc == rv_pkg::OP));

  always_comb begin
    dec.ctl.r_type = (opc == rv_pkg::OP);
    dec.ctl.funct3 = rv_pkg::funct3_e'(instr[14:12]);
    dec.ctl.alt    = instr[30];  // also kept for srai.
    dec.rd         = instr[11:7];
    dec.rs1        = instr[19:15];
    dec.rs2        = instr[24:20];
    dec.use_imm    = (opc == rv_pkg::OP_IMM);
    dec.legal      = legal;
    dec.imm        = {{20{instr[31]}}, instr[31:20]};  // i-type immediate.
  end

  assign issue = instr_valid && legal;

  // the pulse lines up with the write-back slot of the word.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      illegal_q <= 1'b0;
    end else begin
      illegal_q <= instr_valid && !legal;
    end
  end

  assign illegal = illegal_q;

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

  typedef logic [4:0] reg_addr_t;  // register index.

  // major opcode in instr[6:2], only the two integer groups are decoded.
  typedef enum logic [4:0] {
    OP_IMM = 5'b00100,
    OP     = 5'b01100
  } opcode_e;

  typedef enum logic [2:0] {
    ADD_SUB = 3'b000,
    SLL     = 3'b001,
    SLT     = 3'b010,
    SLTU    = 3'b011,
    XOR     = 3'b100,
    SRL_SRA = 3'b101,
    OR      = 3'b110,
    AND     = 3'b111
  } funct3_e;

  // alu control, 5 bits.
  typedef struct packed {
    logic    r_type;  // set for OP.
    funct3_e funct3;
    logic    alt;     // instr[30], picks sub and sra.
  } alu_ctl_t;

  // decoded instruction, 54 bits.
  typedef struct packed {
    alu_ctl_t    ctl;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic        use_imm;  // second operand from imm.
    logic        legal;
    logic [31:0] imm;      // sign-extended i-immediate.
  } dec_t;

  // write-back tag, travels with the alu result.
  typedef struct packed {
    logic      en;
    reg_addr_t rd;
  } wb_tag_t;

endpackage
